// File: Makefile
# Verilator build and run for the read-data path

VERILATOR ?= verilator
TOP       ?= read_data_tb
SEED_ARGS ?= +verilator+seed+1
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(wildcard design/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): src.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f src.f

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: design/command_tag_table.sv
`timescale 1ns/1ps

module command_tag_table #(
  parameter int TAG_WIDTH = read_data_pkg::TAG_WIDTH
) (
  input  logic                       clock,
  input  logic                       rstn,
  input  read_data_pkg::command_issue_t issue,
  input  logic [TAG_WIDTH-1:0]       lookup_tag,
  output read_data_pkg::cmd_type_t   lookup_type
);

  import read_data_pkg::*;

  localparam int ENTRIES = 2 ** TAG_WIDTH;

  // One command type per tag
  cmd_type_t type_table [ENTRIES];

  //////////////////////////////
  // Issue side
  //////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < ENTRIES; i++) begin
        type_table[i] <= CMD_NONE;
      end
    end else begin
      if (issue.valid) begin
        type_table[TAG_WIDTH'(issue.tag)] <= issue.cmd_type;
      end
    end
  end

  //////////////////////////////
  // Lookup side
  //////////////////////////////

  // Same-cycle lookup for the latched buffer write
  assign lookup_type = type_table[lookup_tag];

  // Issuer only announces real commands
  issue_type_known : assert property (
    @(posedge clock) disable iff (!rstn)
    issue.valid |-> (issue.cmd_type != CMD_NONE)
  );

endmodule

// File: design/half_line_ram.sv
`timescale 1ns/1ps

module half_line_ram #(
  parameter int TAG_WIDTH = read_data_pkg::TAG_WIDTH
) (
  input  logic                      clock,
  input  logic                      we,
  input  logic [TAG_WIDTH-1:0]      wr_addr,
  input  read_data_pkg::read_line_t data_in,
  input  logic [TAG_WIDTH-1:0]      rd_addr,
  output read_data_pkg::read_line_t data_out
);

  import read_data_pkg::*;

  localparam int DEPTH = 2 ** TAG_WIDTH;

  read_line_t mem [DEPTH];

  // Write port and registered read port
  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
    data_out <= mem[rd_addr];
  end

endmodule

// File: design/line_parity_check.sv
`timescale 1ns/1ps

module line_parity_check (
  input  logic                          clock,
  input  logic                          rstn,
  input  read_data_pkg::buffer_write_t  write,
  output read_data_pkg::parity_errors_t errors
);

  import read_data_pkg::*;

  logic                       tag_parity;
  logic [DWORDS_PER_HALF-1:0] dword_parity;
  logic                       tag_mismatch;
  logic                       data_mismatch;

  //////////////////////////////
  // Odd parity generation
  //////////////////////////////

  always_comb begin
    tag_parity = ~^write.write_tag;
    for (int i = 0; i < DWORDS_PER_HALF; i++) begin
      dword_parity[i] = ~^write.write_data.dwords[i];
    end
  end

  // Compare against the bits carried by the host
  assign tag_mismatch  = tag_parity != write.write_tag_parity;
  assign data_mismatch = |(dword_parity ^ write.write_parity);

  //////////////////////////////
  // Registered flags
  //////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      errors <= '0;
    end else begin
      if (write.write_valid) begin
        errors.tag_error  <= tag_mismatch;
        errors.data_error <= data_mismatch;
      end else begin
        // Only meaningful for one cycle per write
        errors <= '0;
      end
    end
  end

endmodule

// File: design/read_data_control.sv
`timescale 1ns/1ps

module read_data_control #(
  parameter int TAG_WIDTH = read_data_pkg::TAG_WIDTH
) (
  input  logic                          clock,
  input  logic                          rstn,
  input  logic                          enabled_in,
  input  read_data_pkg::buffer_write_t  buffer_in,
  input  read_data_pkg::response_t      response_in,
  input  read_data_pkg::cmd_type_t      lookup_type,
  output logic [TAG_WIDTH-1:0]          lookup_tag,
  output read_data_pkg::read_line_t     line_out,
  output read_data_pkg::parity_errors_t data_read_error
);

  import read_data_pkg::*;

  logic           enabled;
  buffer_write_t  buffer_latched;
  response_t      response_latched;
  parity_errors_t detected_errors;

  read_line_t           store_line;
  logic                 store_en;
  logic [1:0]           ram_we;
  logic [TAG_WIDTH-1:0] wr_addr;
  logic [TAG_WIDTH-1:0] rd_addr;
  read_line_t           ram_out [2];

  logic       release_pending;
  logic       half1_valid;
  read_line_t half1_line;

  //////////////////////////////
  // Enable and input latching
  //////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled <= 1'b0;
    end else begin
      enabled <= enabled_in;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      buffer_latched   <= '0;
      response_latched <= '0;
    end else begin
      if (enabled) begin
        buffer_latched   <= buffer_in;
        response_latched <= response_in;
      end else begin
        buffer_latched   <= '0;
        response_latched <= '0;
      end
    end
  end

  assign lookup_tag = TAG_WIDTH'(buffer_latched.write_tag);

  //////////////////////////////
  // Half steering into RAM
  //////////////////////////////

  always_comb begin
    store_line           = '0;
    store_line.valid     = buffer_latched.write_valid;
    store_line.half      = buffer_latched.write_address;
    store_line.tag       = buffer_latched.write_tag;
    store_line.read_data = lookup_type == CMD_READ;
    store_line.wed_data  = lookup_type == CMD_WED;
    store_line.data      = buffer_latched.write_data;
  end

  // Data for an unknown tag is dropped
  assign store_en  = buffer_latched.write_valid && (lookup_type != CMD_NONE);
  assign ram_we[0] = store_en && !buffer_latched.write_address;
  assign ram_we[1] = store_en && buffer_latched.write_address;
  assign wr_addr   = TAG_WIDTH'(buffer_latched.write_tag);
  assign rd_addr   = TAG_WIDTH'(response_latched.tag);

  for (genvar h = 0; h < 2; h++) begin : g_half
    half_line_ram #(
      .TAG_WIDTH(TAG_WIDTH)
    ) half_line_ram_inst (
      .clock   (clock),
      .we      (ram_we[h]),
      .wr_addr (wr_addr),
      .data_in (store_line),
      .rd_addr (rd_addr),
      .data_out(ram_out[h])
    );
  end

  //////////////////////////////
  // Parity errors
  //////////////////////////////

  line_parity_check line_parity_check_inst (
    .clock (clock),
    .rstn  (rstn),
    .write (buffer_latched),
    .errors(detected_errors)
  );

  assign data_read_error = enabled ? detected_errors : '0;

  //////////////////////////////
  // Response-driven release
  //////////////////////////////

  // Lines up with the RAM read data
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      release_pending <= 1'b0;
      half1_valid     <= 1'b0;
    end else begin
      release_pending <= response_latched.valid &&
                         (response_latched.cmd_type inside {CMD_READ, CMD_WED});
      half1_valid     <= release_pending;
    end
  end

  // Half 1 waits one cycle behind half 0
  always_ff @(posedge clock) begin
    if (release_pending) begin
      half1_line <= ram_out[1];
    end
  end

  always_comb begin
    line_out = '0;
    if (half1_valid) begin
      line_out       = half1_line;
      line_out.valid = 1'b1;
      line_out.half  = 1'b1;
    end else if (release_pending) begin
      line_out       = ram_out[0];
      line_out.valid = 1'b1;
      line_out.half  = 1'b0;
    end
  end

  // Responses must be spaced so the two halves never overlap
  halves_exclusive : assert property (
    @(posedge clock) disable iff (!rstn)
    !(half1_valid && release_pending)
  );

  // Both halves read back for a response were stored with exactly one type
  stored_type_onehot : assert property (
    @(posedge clock) disable iff (!rstn)
    release_pending |-> $onehot({ram_out[0].read_data, ram_out[0].wed_data}) &&
                        $onehot({ram_out[1].read_data, ram_out[1].wed_data})
  );

endmodule

// File: design/read_data_pkg.sv
package read_data_pkg;

  //////////////////////////////
  // Bus dimensions
  //////////////////////////////

  // Default tag width that the top level overrides
  localparam int TAG_WIDTH = 8;

  // Fixed by the host bus
  localparam int DWORDS_PER_HALF = 8;

  //////////////////////////////
  // Command types
  //////////////////////////////

  typedef enum logic [1:0] {
    CMD_NONE = 2'd0,
    CMD_READ = 2'd1,
    CMD_WED  = 2'd2
  } cmd_type_t;

  //////////////////////////////
  // Payload and interfaces
  //////////////////////////////

  // One half of a cacheline as flat bits or as double words
  typedef union packed {
    logic [511:0]                     bits;
    logic [DWORDS_PER_HALF-1:0][63:0] dwords;
  } half_line_t;

  // Host buffer-write port carrying one half-line per strobe
  typedef struct packed {
    logic                       write_valid;
    logic [TAG_WIDTH-1:0]       write_tag;
    logic                       write_address;
    logic                       write_tag_parity;
    half_line_t                 write_data;
    logic [DWORDS_PER_HALF-1:0] write_parity;
  } buffer_write_t;

  // Outstanding command announced by the issuer
  typedef struct packed {
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
    cmd_type_t            cmd_type;
  } command_issue_t;

  // Host response whose type says read or WED
  typedef struct packed {
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
    cmd_type_t            cmd_type;
  } response_t;

  // Released half-line and RAM entry format
  typedef struct packed {
    logic                 valid;
    logic                 half;
    logic [TAG_WIDTH-1:0] tag;
    logic                 read_data;
    logic                 wed_data;
    half_line_t           data;
  } read_line_t;

  typedef struct packed {
    logic tag_error;
    logic data_error;
  } parity_errors_t;

endpackage

// File: design/read_data_top.sv
`timescale 1ns/1ps

module read_data_top #(
  parameter int TAG_WIDTH = read_data_pkg::TAG_WIDTH
) (
  input  logic                          clock,
  input  logic                          rstn,
  input  logic                          enabled_in,
  input  read_data_pkg::command_issue_t issue,
  input  read_data_pkg::buffer_write_t  buffer_in,
  input  read_data_pkg::response_t      response_in,
  output read_data_pkg::read_line_t     line_out,
  output read_data_pkg::parity_errors_t data_read_error
);

  import read_data_pkg::*;

  logic [TAG_WIDTH-1:0] lookup_tag;
  cmd_type_t            lookup_type;

  // Command type per outstanding tag
  command_tag_table #(
    .TAG_WIDTH(TAG_WIDTH)
  ) command_tag_table_inst (
    .clock      (clock),
    .rstn       (rstn),
    .issue      (issue),
    .lookup_tag (lookup_tag),
    .lookup_type(lookup_type)
  );

  // Buffering, parity and release of both halves
  read_data_control #(
    .TAG_WIDTH(TAG_WIDTH)
  ) read_data_control_inst (
    .clock          (clock),
    .rstn           (rstn),
    .enabled_in     (enabled_in),
    .buffer_in      (buffer_in),
    .response_in    (response_in),
    .lookup_type    (lookup_type),
    .lookup_tag     (lookup_tag),
    .line_out       (line_out),
    .data_read_error(data_read_error)
  );

endmodule

// File: src.f
+incdir+test
design/read_data_pkg.sv
design/command_tag_table.sv
design/line_parity_check.sv
design/half_line_ram.sv
design/read_data_control.sv
design/read_data_top.sv
test/read_data_tb.sv

// File: test/read_data_checks.svh
`ifndef READ_DATA_CHECKS_SVH
`define READ_DATA_CHECKS_SVH

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic compare_line(input string name, input read_line_t expected,
                            input read_line_t actual);
  if (actual !== expected) begin
    $display("Fail %s expected %h actual %h", name, expected, actual);
    end_with_failure();
  end
endtask

task automatic compare_errors(input string name, input parity_errors_t expected,
                              input parity_errors_t actual);
  if (actual !== expected) begin
    $display("Fail %s expected %b actual %b", name, expected, actual);
    end_with_failure();
  end
endtask

//////////////////////////////
// Expected-value model
//////////////////////////////

// Parity bit that makes the total number of ones odd
function automatic logic odd_parity_bit(input logic [63:0] value);
  int ones;
  ones = 0;
  for (int b = 0; b < 64; b++) begin
    if (value[b]) begin
      ones++;
    end
  end
  return (ones % 2) == 0;
endfunction

function automatic half_line_t random_half();
  half_line_t value;
  value = '0;
  for (int w = 0; w < 16; w++) begin
    value.bits[32*w +: 32] = $urandom();
  end
  return value;
endfunction

// One buffer write with an optional flipped tag or dword parity bit
function automatic buffer_write_t build_buffer_write(input logic [TAG_WIDTH-1:0] tag,
                                                     input logic half,
                                                     input half_line_t data,
                                                     input bit bad_tag,
                                                     input int bad_dword);
  buffer_write_t write;
  write = '0;
  write.write_valid      = 1'b1;
  write.write_tag        = tag;
  write.write_address    = half;
  write.write_tag_parity = odd_parity_bit(64'(tag)) ^ bad_tag;
  write.write_data       = data;
  for (int d = 0; d < DWORDS_PER_HALF; d++) begin
    write.write_parity[d] = odd_parity_bit(data.dwords[d]);
    if (d == bad_dword) begin
      write.write_parity[d] = ~write.write_parity[d];
    end
  end
  return write;
endfunction

function automatic response_t build_response(input logic [TAG_WIDTH-1:0] tag,
                                             input cmd_type_t cmd);
  response_t response;
  response = '0;
  response.valid    = 1'b1;
  response.tag      = tag;
  response.cmd_type = cmd;
  return response;
endfunction

// Released half carries its tag, its data and one type flag
function automatic read_line_t expected_release(input logic [TAG_WIDTH-1:0] tag,
                                                input cmd_type_t cmd,
                                                input logic half,
                                                input half_line_t data);
  read_line_t line;
  line = '0;
  line.valid     = 1'b1;
  line.half      = half;
  line.tag       = tag;
  line.read_data = cmd == CMD_READ;
  line.wed_data  = cmd == CMD_WED;
  line.data      = data;
  return line;
endfunction

`endif

// File: test/read_data_tb.sv
`timescale 1ns/1ps

module read_data_tb;

  import read_data_pkg::*;

  localparam int          TAG_WIDTH       = read_data_pkg::TAG_WIDTH;
  localparam int          CLOCK_PERIOD    = 100;
  localparam int          NUM_TESTS       = 10;
  localparam int          WATCHDOG_CYCLES = NUM_TESTS * 20;
  localparam logic [31:0] SEED            = 32'hcf7f_930b;

  localparam read_line_t     IDLE_LINE = '0;
  localparam parity_errors_t NO_ERR    = '{1'b0, 1'b0};
  localparam parity_errors_t TAG_ERR   = '{1'b1, 1'b0};
  localparam parity_errors_t DATA_ERR  = '{1'b0, 1'b1};

  // One row of the stimulus table
  typedef struct {
    string                name;
    logic [TAG_WIDTH-1:0] tag;
    cmd_type_t            cmd;
    bit                   bad_tag_parity;
    int                   bad_dword;
    bit                   half1_first;
    bit                   enable;
    int                   slot;
    parity_errors_t       exp_errors;
  } test_entry_t;

  logic           clock;
  logic           rstn;
  logic           enabled_in;
  command_issue_t issue;
  buffer_write_t  buffer_in;
  response_t      response_in;
  read_line_t     line_out;
  parity_errors_t data_read_error;

  test_entry_t tests [NUM_TESTS];
  half_line_t  written [NUM_TESTS][2];

  read_data_top #(
    .TAG_WIDTH(TAG_WIDTH)
  ) read_data_top_inst (
    .clock          (clock),
    .rstn           (rstn),
    .enabled_in     (enabled_in),
    .issue          (issue),
    .buffer_in      (buffer_in),
    .response_in    (response_in),
    .line_out       (line_out),
    .data_read_error(data_read_error)
  );

  task automatic end_with_failure();
    $display("Done: errors found");
    $fatal(1);
  endtask

  `include "read_data_checks.svh"

  task automatic next_cycle();
    @(negedge clock);
  endtask

  // Enable register lags one cycle, so give it a spare cycle
  task automatic apply_enable(input logic value);
    if (enabled_in !== value) begin
      next_cycle();
      enabled_in = value;
    end
  endtask

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout: run still going after %0d cycles", WATCHDOG_CYCLES);
    end_with_failure();
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int         slot_entry [NUM_TESTS];
    int         num_slots;
    int         e;
    logic       first_half;
    logic       half;
    read_line_t expected;

    void'($urandom(SEED));

    // name, tag, type, bad tag parity, bad dword, half 1 first, enable, slot, flags
    tests[0] = '{"read_half0_first", 8'h03, CMD_READ, 1'b0, -1, 1'b0, 1'b1, 0, NO_ERR};
    tests[1] = '{"read_half1_first", 8'h5a, CMD_READ, 1'b0, -1, 1'b1, 1'b1, 1, NO_ERR};
    tests[2] = '{"wed_line", 8'hc4, CMD_WED, 1'b0, -1, 1'b0, 1'b1, 2, NO_ERR};
    tests[3] = '{"tag_parity_error", 8'h21, CMD_READ, 1'b1, -1, 1'b0, 1'b1, 3, TAG_ERR};
    tests[4] = '{"dword_parity_error", 8'h7e, CMD_WED, 1'b0, 5, 1'b1, 1'b1, 4, DATA_ERR};
    tests[5] = '{"reorder_a", 8'h90, CMD_READ, 1'b0, -1, 1'b0, 1'b1, 7, NO_ERR};
    tests[6] = '{"reorder_b", 8'h91, CMD_WED, 1'b0, -1, 1'b1, 1'b1, 5, NO_ERR};
    tests[7] = '{"reorder_c", 8'hff, CMD_READ, 1'b0, -1, 1'b0, 1'b1, 6, NO_ERR};
    tests[8] = '{"disabled_read", 8'h44, CMD_READ, 1'b1, 2, 1'b0, 1'b0, -1, NO_ERR};
    tests[9] = '{"disabled_wed", 8'h00, CMD_WED, 1'b0, -1, 1'b1, 1'b0, -1, NO_ERR};

    rstn        = 1'b0;
    enabled_in  = 1'b1;
    issue       = '0;
    buffer_in   = '0;
    response_in = '0;

    // Two clock edges with reset low
    next_cycle();
    compare_line("reset line", IDLE_LINE, line_out);
    compare_errors("reset flags", NO_ERR, data_read_error);
    next_cycle();
    rstn = 1'b1;
    next_cycle();
    compare_line("after reset line", IDLE_LINE, line_out);
    compare_errors("after reset flags", NO_ERR, data_read_error);

    ////////////////////////////// Issue and write every tag

    for (int i = 0; i < NUM_TESTS; i++) begin
      apply_enable(tests[i].enable);
      first_half    = tests[i].half1_first;
      written[i][0] = random_half();
      written[i][1] = random_half();

      next_cycle();
      issue.valid    = 1'b1;
      issue.tag      = tests[i].tag;
      issue.cmd_type = tests[i].cmd;

      // Only the first written half carries the corruption
      next_cycle();
      issue     = '0;
      buffer_in = build_buffer_write(tests[i].tag, first_half, written[i][first_half],
                                     tests[i].bad_tag_parity, tests[i].bad_dword);

      next_cycle();
      compare_errors($sformatf("%s flags before", tests[i].name), NO_ERR, data_read_error);
      compare_line($sformatf("%s idle write", tests[i].name), IDLE_LINE, line_out);
      buffer_in = build_buffer_write(tests[i].tag, !first_half, written[i][!first_half],
                                     1'b0, -1);

      next_cycle();
      buffer_in = '0;
      compare_errors($sformatf("%s flags first half", tests[i].name),
                     tests[i].exp_errors, data_read_error);
      compare_line($sformatf("%s idle write", tests[i].name), IDLE_LINE, line_out);

      next_cycle();
      compare_errors($sformatf("%s flags second half", tests[i].name),
                     NO_ERR, data_read_error);

      next_cycle();
      compare_errors($sformatf("%s flags cleared", tests[i].name), NO_ERR, data_read_error);
      compare_line($sformatf("%s idle write", tests[i].name), IDLE_LINE, line_out);

      // A disabled response must release nothing
      if (!tests[i].enable) begin
        response_in = build_response(tests[i].tag, tests[i].cmd);
        repeat (4) begin
          next_cycle();
          response_in = '0;
          compare_line($sformatf("%s no release", tests[i].name), IDLE_LINE, line_out);
          compare_errors($sformatf("%s no flags", tests[i].name), NO_ERR, data_read_error);
        end
      end
    end

    ////////////////////////////// Responses in slot order

    num_slots = 0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (tests[i].enable) begin
        slot_entry[tests[i].slot] = i;
        num_slots++;
      end
    end

    apply_enable(1'b1);

    // Every second cycle so the halves of two lines never collide
    for (int c = 0; c <= 2 * num_slots + 2; c++) begin
      next_cycle();
      if (c >= 2 && (c - 2) / 2 < num_slots) begin
        e        = slot_entry[(c - 2) / 2];
        half     = ((c - 2) % 2) == 1;
        expected = expected_release(tests[e].tag, tests[e].cmd, half, written[e][half]);
        compare_line($sformatf("%s half%0d", tests[e].name, half), expected, line_out);
      end else begin
        compare_line("release idle", IDLE_LINE, line_out);
      end
      compare_errors("release flags", NO_ERR, data_read_error);

      if (c % 2 == 0 && c / 2 < num_slots) begin
        e           = slot_entry[c / 2];
        response_in = build_response(tests[e].tag, tests[e].cmd);
      end else begin
        response_in = '0;
      end
    end

    $display("Done: no errors");
    $finish;
  end

endmodule
